// File: rv_defines.svh
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// architectural widths
`define RV_XLEN      32
`define RV_REG_AW    5
`define RV_RESET_PC  32'h0000_0000

// major opcodes
`define RV_OP_LUI    7'b0110111
`define RV_OP_AUIPC  7'b0010111
`define RV_OP_JAL    7'b1101111
`define RV_OP_JALR   7'b1100111
`define RV_OP_BRANCH 7'b1100011
`define RV_OP_LOAD   7'b0000011
`define RV_OP_STORE  7'b0100011
`define RV_OP_IMM    7'b0010011
`define RV_OP_REG    7'b0110011
`define RV_OP_SYSTEM 7'b1110011

// funct3 for jalr and branches
`define RV_F3_JALR   3'b000
`define RV_F3_BEQ    3'b000
`define RV_F3_BNE    3'b001
`define RV_F3_BLT    3'b100
`define RV_F3_BGE    3'b101
`define RV_F3_BLTU   3'b110
`define RV_F3_BGEU   3'b111

// funct3 for loads and stores
`define RV_F3_B      3'b000
`define RV_F3_H      3'b001
`define RV_F3_W      3'b010
`define RV_F3_BU     3'b100
`define RV_F3_HU     3'b101

// funct3 for alu ops
`define RV_F3_ADD    3'b000
`define RV_F3_SLL    3'b001
`define RV_F3_SLT    3'b010
`define RV_F3_SLTU   3'b011
`define RV_F3_XOR    3'b100
`define RV_F3_SRL    3'b101
`define RV_F3_OR     3'b110
`define RV_F3_AND    3'b111

// funct7, alternate form selects sub and sra
`define RV_F7_BASE   7'b0000000
`define RV_F7_ALT    7'b0100000

`define RV_EBREAK    32'h0010_0073

`endif

// File: rv_pkg.sv
`default_nettype none

`include "rv_defines.svh"

package rv_pkg;

	typedef logic [`RV_XLEN-1:0]   word_t;
	typedef logic [`RV_REG_AW-1:0] reg_addr_t;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		// lui just forwards the immediate
		ALU_PASS_B
	} alu_op_e;

	typedef enum logic {SRC_A_RS1, SRC_A_PC} src_a_e;
	typedef enum logic {SRC_B_RS2, SRC_B_IMM} src_b_e;

	typedef enum logic [2:0] {BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU} branch_e;
	typedef enum logic [1:0] {JMP_NONE, JMP_JAL, JMP_JALR} jump_e;
	typedef enum logic [1:0] {MEM_BYTE, MEM_HALF, MEM_WORD} mem_size_e;
	typedef enum logic [1:0] {WB_ALU, WB_LOAD, WB_PC4} wb_sel_e;

endpackage

`default_nettype wire

// File: rv_stage_if.sv
`timescale 1ns/10ps
`default_nettype none

// decoded instruction plus its operands
interface id_ex_if import rv_pkg::*; ();
	word_t     pc;
	word_t     rs1_data;
	word_t     rs2_data;
	word_t     imm;
	alu_op_e   alu_op;
	src_a_e    src_a;
	src_b_e    src_b;
	branch_e   branch;
	jump_e     jump;
	logic      load;
	logic      store;
	mem_size_e mem_size;
	logic      load_unsigned;
	reg_addr_t rd;
	logic      reg_we;
	wb_sel_e   wb_sel;

	modport decoder (output pc, rs1_data, rs2_data, imm, alu_op, src_a, src_b, branch, jump,
		load, store, mem_size, load_unsigned, rd, reg_we, wb_sel);
	modport execute (input pc, rs1_data, rs2_data, imm, alu_op, src_a, src_b, branch, jump,
		load, store, mem_size, load_unsigned, rd, reg_we, wb_sel);
endinterface

// what writeback needs to finish the instruction
interface ex_wb_if import rv_pkg::*; ();
	word_t      alu_result;
	word_t      pc_plus4;
	logic       load;
	mem_size_e  mem_size;
	logic       load_unsigned;
	logic [1:0] addr_lo;
	reg_addr_t  rd;
	logic       reg_we;
	wb_sel_e    wb_sel;

	modport execute (output alu_result, pc_plus4, load, mem_size, load_unsigned, addr_lo, rd,
		reg_we, wb_sel);
	modport writeback (input alu_result, pc_plus4, load, mem_size, load_unsigned, addr_lo, rd,
		reg_we, wb_sel);
endinterface

`default_nettype wire

// File: rv_pc_counter.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_defines.svh"

module rv_pc_counter import rv_pkg::*; (
	input  logic  clk,
	input  logic  rst,
	input  logic  redirect_i,
	input  word_t target_i,
	input  logic  halt_i,
	output word_t pc_o
);

	word_t pc_q;
	logic  halted_q;

	always_ff @(posedge clk) begin
		if (!rst) begin
			pc_q     <= `RV_RESET_PC;
			halted_q <= 1'b0;
		end else begin
			// once ebreak is seen the core stays frozen
			if (halt_i)
				halted_q <= 1'b1;
			if (!(halt_i || halted_q))
				pc_q <= redirect_i ? target_i : pc_q + 32'd4;
		end
	end

	assign pc_o = pc_q;

endmodule

`default_nettype wire

// File: rv_regfile.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_defines.svh"

module rv_regfile import rv_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  reg_addr_t raddr1_i,
	input  reg_addr_t raddr2_i,
	output word_t     rdata1_o,
	output word_t     rdata2_o,
	input  logic      we_i,
	input  reg_addr_t waddr_i,
	input  word_t     wdata_i
);

	localparam int NUM_REGS = 2 ** `RV_REG_AW;

	word_t regs [NUM_REGS];

	always_ff @(posedge clk) begin
		if (!rst) begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end else if (we_i && waddr_i != '0) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	// x0 reads as zero whatever the array holds
	assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
	assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

`default_nettype wire

// File: rv_decoder.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_defines.svh"

module rv_decoder import rv_pkg::*; (
	input  word_t     inst_i,
	input  word_t     pc_i,
	input  word_t     rs1_data_i,
	input  word_t     rs2_data_i,
	output reg_addr_t rs1_addr_o,
	output reg_addr_t rs2_addr_o,
	output logic      halt_o,
	output logic      invalid_o,
	id_ex_if.decoder  de
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	word_t      imm_i, imm_s, imm_b, imm_u, imm_j;
	alu_op_e    alu_f3;
	logic       illegal;

	assign opcode = inst_i[6:0];
	assign funct3 = inst_i[14:12];
	assign funct7 = inst_i[31:25];

	assign rs1_addr_o = inst_i[19:15];
	assign rs2_addr_o = inst_i[24:20];

	assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
	assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
	assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
	assign imm_u = {inst_i[31:12], 12'b0};
	assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

	// shared by op-imm and op, sub only exists in register form
	always_comb begin
		case (funct3)
			`RV_F3_ADD:  alu_f3 = (opcode == `RV_OP_REG && inst_i[30]) ? ALU_SUB : ALU_ADD;
			`RV_F3_SLL:  alu_f3 = ALU_SLL;
			`RV_F3_SLT:  alu_f3 = ALU_SLT;
			`RV_F3_SLTU: alu_f3 = ALU_SLTU;
			`RV_F3_XOR:  alu_f3 = ALU_XOR;
			`RV_F3_SRL:  alu_f3 = inst_i[30] ? ALU_SRA : ALU_SRL;
			`RV_F3_OR:   alu_f3 = ALU_OR;
			default:     alu_f3 = ALU_AND;
		endcase
	end

	always_comb begin
		de.pc            = pc_i;
		de.rs1_data      = rs1_data_i;
		de.rs2_data      = rs2_data_i;
		de.rd            = inst_i[11:7];
		de.imm           = imm_i;
		de.alu_op        = ALU_ADD;
		de.src_a         = SRC_A_RS1;
		de.src_b         = SRC_B_IMM;
		de.branch        = BR_NONE;
		de.jump          = JMP_NONE;
		de.load          = 1'b0;
		de.store         = 1'b0;
		de.mem_size      = MEM_WORD;
		de.load_unsigned = 1'b0;
		de.reg_we        = 1'b0;
		de.wb_sel        = WB_ALU;
		illegal          = 1'b0;

		case (opcode)
			`RV_OP_LUI: begin
				de.imm    = imm_u;
				de.alu_op = ALU_PASS_B;
				de.reg_we = 1'b1;
			end
			`RV_OP_AUIPC: begin
				de.imm    = imm_u;
				de.src_a  = SRC_A_PC;
				de.reg_we = 1'b1;
			end
			`RV_OP_JAL: begin
				de.imm    = imm_j;
				de.jump   = JMP_JAL;
				de.wb_sel = WB_PC4;
				de.reg_we = 1'b1;
			end
			`RV_OP_JALR: begin
				de.jump   = JMP_JALR;
				de.wb_sel = WB_PC4;
				de.reg_we = 1'b1;
				illegal   = (funct3 != `RV_F3_JALR);
			end
			`RV_OP_BRANCH: begin
				de.imm   = imm_b;
				de.src_b = SRC_B_RS2;
				case (funct3)
					`RV_F3_BEQ:  de.branch = BR_EQ;
					`RV_F3_BNE:  de.branch = BR_NE;
					`RV_F3_BLT:  de.branch = BR_LT;
					`RV_F3_BGE:  de.branch = BR_GE;
					`RV_F3_BLTU: de.branch = BR_LTU;
					`RV_F3_BGEU: de.branch = BR_GEU;
					default:     illegal = 1'b1;
				endcase
			end
			`RV_OP_LOAD: begin
				de.load   = 1'b1;
				de.wb_sel = WB_LOAD;
				de.reg_we = 1'b1;
				de.load_unsigned = funct3[2];
				case (funct3)
					`RV_F3_B, `RV_F3_BU: de.mem_size = MEM_BYTE;
					`RV_F3_H, `RV_F3_HU: de.mem_size = MEM_HALF;
					`RV_F3_W:            de.mem_size = MEM_WORD;
					default:             illegal = 1'b1;
				endcase
			end
			`RV_OP_STORE: begin
				de.imm   = imm_s;
				de.store = 1'b1;
				case (funct3)
					`RV_F3_B: de.mem_size = MEM_BYTE;
					`RV_F3_H: de.mem_size = MEM_HALF;
					`RV_F3_W: de.mem_size = MEM_WORD;
					default:  illegal = 1'b1;
				endcase
			end
			`RV_OP_IMM: begin
				de.alu_op = alu_f3;
				de.reg_we = 1'b1;
				// shift immediates only allow the two funct7 forms
				if (funct3 == `RV_F3_SLL)
					illegal = (funct7 != `RV_F7_BASE);
				else if (funct3 == `RV_F3_SRL)
					illegal = (funct7 != `RV_F7_BASE) && (funct7 != `RV_F7_ALT);
			end
			`RV_OP_REG: begin
				de.src_b  = SRC_B_RS2;
				de.alu_op = alu_f3;
				de.reg_we = 1'b1;
				illegal   = !((funct7 == `RV_F7_BASE) || ((funct7 == `RV_F7_ALT) &&
					(funct3 == `RV_F3_ADD || funct3 == `RV_F3_SRL)));
			end
			`RV_OP_SYSTEM: illegal = (inst_i != `RV_EBREAK);
			default:       illegal = 1'b1;
		endcase

		// illegal words retire as a no-op
		if (illegal) begin
			de.reg_we = 1'b0;
			de.load   = 1'b0;
			de.store  = 1'b0;
			de.branch = BR_NONE;
			de.jump   = JMP_NONE;
		end
	end

	assign halt_o    = (inst_i == `RV_EBREAK);
	assign invalid_o = illegal;

endmodule

`default_nettype wire

// File: rv_execute.sv
`timescale 1ns/10ps
`default_nettype none

module rv_execute import rv_pkg::*; (
	id_ex_if.execute  de,
	ex_wb_if.execute  ew,
	output logic       redirect_o,
	output word_t      target_o,
	output word_t      dmem_addr_o,
	output logic       dmem_we_o,
	output logic [3:0] dmem_be_o,
	output word_t      dmem_wdata_o
);

	word_t op_a;
	word_t op_b;
	word_t alu_res;
	word_t jump_sum;
	logic  taken;

	assign op_a = (de.src_a == SRC_A_PC) ? de.pc : de.rs1_data;
	assign op_b = (de.src_b == SRC_B_IMM) ? de.imm : de.rs2_data;

	always_comb begin
		case (de.alu_op)
			ALU_SUB:    alu_res = op_a - op_b;
			ALU_SLL:    alu_res = op_a << op_b[4:0];
			ALU_SLT:    alu_res = word_t'($signed(op_a) < $signed(op_b));
			ALU_SLTU:   alu_res = word_t'(op_a < op_b);
			ALU_XOR:    alu_res = op_a ^ op_b;
			ALU_SRL:    alu_res = op_a >> op_b[4:0];
			ALU_SRA:    alu_res = word_t'($signed(op_a) >>> op_b[4:0]);
			ALU_OR:     alu_res = op_a | op_b;
			ALU_AND:    alu_res = op_a & op_b;
			ALU_PASS_B: alu_res = op_b;
			default:    alu_res = op_a + op_b;
		endcase
	end

	// branches always compare the two register operands
	always_comb begin
		case (de.branch)
			BR_EQ:   taken = (de.rs1_data == de.rs2_data);
			BR_NE:   taken = (de.rs1_data != de.rs2_data);
			BR_LT:   taken = ($signed(de.rs1_data) < $signed(de.rs2_data));
			BR_GE:   taken = ($signed(de.rs1_data) >= $signed(de.rs2_data));
			BR_LTU:  taken = (de.rs1_data < de.rs2_data);
			BR_GEU:  taken = (de.rs1_data >= de.rs2_data);
			default: taken = 1'b0;
		endcase
	end

	// jalr is relative to rs1, jal and branches to pc
	assign jump_sum   = ((de.jump == JMP_JALR) ? de.rs1_data : de.pc) + de.imm;
	assign target_o   = (de.jump == JMP_JALR) ? {jump_sum[31:1], 1'b0} : jump_sum;
	assign redirect_o = (de.jump != JMP_NONE) || taken;

	// stores go out word aligned, lanes picked by the low address bits
	assign dmem_addr_o = {alu_res[31:2], 2'b00};
	assign dmem_we_o   = de.store;

	always_comb begin
		case (de.mem_size)
			MEM_BYTE: begin
				dmem_be_o    = 4'b0001 << alu_res[1:0];
				dmem_wdata_o = {4{de.rs2_data[7:0]}};
			end
			MEM_HALF: begin
				dmem_be_o    = alu_res[1] ? 4'b1100 : 4'b0011;
				dmem_wdata_o = {2{de.rs2_data[15:0]}};
			end
			default: begin
				dmem_be_o    = 4'b1111;
				dmem_wdata_o = de.rs2_data;
			end
		endcase
	end

	assign ew.alu_result    = alu_res;
	assign ew.pc_plus4      = de.pc + 32'd4;
	assign ew.load          = de.load;
	assign ew.mem_size      = de.mem_size;
	assign ew.load_unsigned = de.load_unsigned;
	assign ew.addr_lo       = alu_res[1:0];
	assign ew.rd            = de.rd;
	assign ew.reg_we        = de.reg_we;
	assign ew.wb_sel        = de.wb_sel;

endmodule

`default_nettype wire

// File: rv_writeback.sv
`timescale 1ns/10ps
`default_nettype none

module rv_writeback import rv_pkg::*; (
	ex_wb_if.writeback ew,
	input  word_t      dmem_rdata_i,
	output logic       we_o,
	output reg_addr_t  rd_o,
	output word_t      wdata_o
);

	logic [7:0]  lane_b;
	logic [15:0] lane_h;
	logic        sign_b;
	logic        sign_h;
	word_t       load_data;

	assign lane_b = dmem_rdata_i[{ew.addr_lo, 3'b000} +: 8];
	assign lane_h = ew.addr_lo[1] ? dmem_rdata_i[31:16] : dmem_rdata_i[15:0];
	assign sign_b = !ew.load_unsigned && lane_b[7];
	assign sign_h = !ew.load_unsigned && lane_h[15];

	// extractor stays at zero unless a load is retiring
	always_comb begin
		load_data = '0;
		if (ew.load) begin
			case (ew.mem_size)
				MEM_BYTE: load_data = {{24{sign_b}}, lane_b};
				MEM_HALF: load_data = {{16{sign_h}}, lane_h};
				default:  load_data = dmem_rdata_i;
			endcase
		end
	end

	always_comb begin
		case (ew.wb_sel)
			WB_LOAD: wdata_o = load_data;
			WB_PC4:  wdata_o = ew.pc_plus4;
			default: wdata_o = ew.alu_result;
		endcase
	end

	// rd of x0 never counts as a write
	assign we_o = ew.reg_we && (ew.rd != '0);
	assign rd_o = ew.rd;

endmodule

`default_nettype wire

// File: rv_core_top.sv
`timescale 1ns/10ps
`default_nettype none

module rv_core_top import rv_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	output word_t      pc_o,
	input  word_t      imem_rdata_i,
	output word_t      dmem_addr_o,
	output logic       dmem_we_o,
	output logic [3:0] dmem_be_o,
	output word_t      dmem_wdata_o,
	input  word_t      dmem_rdata_i,
	output logic       commit_we_o,
	output reg_addr_t  commit_rd_o,
	output word_t      commit_data_o,
	output logic       halt_o,
	output logic       invalid_o
);

	word_t     pc;
	reg_addr_t rs1_addr, rs2_addr;
	word_t     rs1_data, rs2_data;
	logic      redirect;
	word_t     target;
	logic      dec_halt, dec_invalid;
	logic      ex_dmem_we;
	logic      wb_we;
	reg_addr_t wb_rd;
	word_t     wb_wdata;

	id_ex_if id_ex ();
	ex_wb_if ex_wb ();

	rv_pc_counter u_pc_counter (
		.clk        (clk),
		.rst        (rst),
		.redirect_i (redirect),
		.target_i   (target),
		.halt_i     (dec_halt),
		.pc_o       (pc)
	);

	rv_regfile u_regfile (
		.clk      (clk),
		.rst      (rst),
		.raddr1_i (rs1_addr),
		.raddr2_i (rs2_addr),
		.rdata1_o (rs1_data),
		.rdata2_o (rs2_data),
		.we_i     (wb_we),
		.waddr_i  (wb_rd),
		.wdata_i  (wb_wdata)
	);

	rv_decoder u_decoder (
		.inst_i     (imem_rdata_i),
		.pc_i       (pc),
		.rs1_data_i (rs1_data),
		.rs2_data_i (rs2_data),
		.rs1_addr_o (rs1_addr),
		.rs2_addr_o (rs2_addr),
		.halt_o     (dec_halt),
		.invalid_o  (dec_invalid),
		.de         (id_ex.decoder)
	);

	rv_execute u_execute (
		.de           (id_ex.execute),
		.ew           (ex_wb.execute),
		.redirect_o   (redirect),
		.target_o     (target),
		.dmem_addr_o  (dmem_addr_o),
		.dmem_we_o    (ex_dmem_we),
		.dmem_be_o    (dmem_be_o),
		.dmem_wdata_o (dmem_wdata_o)
	);

	rv_writeback u_writeback (
		.ew           (ex_wb.writeback),
		.dmem_rdata_i (dmem_rdata_i),
		.we_o         (wb_we),
		.rd_o         (wb_rd),
		.wdata_o      (wb_wdata)
	);

	assign pc_o = pc;

	// strobes and status stay quiet while reset is held
	assign dmem_we_o     = rst && ex_dmem_we;
	assign commit_we_o   = rst && wb_we;
	assign commit_rd_o   = wb_rd;
	assign commit_data_o = wb_wdata;
	assign halt_o        = rst && dec_halt;
	assign invalid_o     = rst && dec_invalid;

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
	output logic clk_o
);

	// 100 ns period, first rising edge at 50 ns
	localparam int HALF_PERIOD = 50;

	initial begin
		clk_o = 1'b0;
		forever #(HALF_PERIOD) clk_o = ~clk_o;
	end

endmodule

`default_nettype wire

// File: tb_checker.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_defines.svh"

module tb_checker import rv_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  word_t      pc_i,
	input  word_t      dmem_addr_i,
	input  logic       dmem_we_i,
	input  logic [3:0] dmem_be_i,
	input  word_t      dmem_wdata_i,
	input  logic       commit_we_i,
	input  reg_addr_t  commit_rd_i,
	input  word_t      commit_data_i,
	input  logic       halt_i,
	input  logic       invalid_i,
	output int         checks_o,
	output int         errors_o
);

	word_t regs [32];
	word_t mem [256];
	word_t pc;

	task automatic expect_value(input string name, input word_t got, input word_t exp);
		checks_o++;
		if (got !== exp) begin
			errors_o++;
			$display("error at %0t: %s expected %h got %h", $time, name, exp, got);
		end
	endtask

	function automatic word_t alu_model(input logic [2:0] f3, input logic alt, input word_t a,
			input word_t b);
		word_t r;
		case (f3)
			3'd0: r = alt ? a - b : a + b;
			3'd1: r = a << b[4:0];
			3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: r = (a < b) ? 32'd1 : 32'd0;
			3'd4: r = a ^ b;
			3'd5: begin
				if (alt)
					r = $signed(a) >>> b[4:0];
				else
					r = a >> b[4:0];
			end
			3'd6: r = a | b;
			default: r = a & b;
		endcase
		return r;
	endfunction

	// one instruction per edge, compared before the model state moves on
	always @(posedge clk) begin
		word_t      inst, a, b, res, next_pc, addr, word, st_data, mask;
		word_t      imm_i, imm_s, imm_b, imm_j;
		logic       exp_we, exp_st, bad, taken;
		logic [3:0] exp_be;
		logic [2:0] f3;
		logic [6:0] f7;
		reg_addr_t  rd;
		if (!rst) begin
			pc = `RV_RESET_PC;
			checks_o = 0;
			errors_o = 0;
			for (int k = 0; k < 32; k++)
				regs[k] = '0;
			for (int k = 0; k < 256; k++)
				mem[k] = tb_top.dmem[k];
		end else begin
			inst    = tb_top.imem[pc[9:2]];
			f3      = inst[14:12];
			f7      = inst[31:25];
			rd      = inst[11:7];
			a       = regs[inst[19:15]];
			b       = regs[inst[24:20]];
			imm_i   = {{20{inst[31]}}, inst[31:20]};
			imm_s   = {{20{inst[31]}}, inst[31:25], inst[11:7]};
			imm_b   = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
			imm_j   = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
			next_pc = pc + 32'd4;
			exp_we  = 1'b0;
			exp_st  = 1'b0;
			bad     = 1'b0;
			taken   = 1'b0;
			res     = '0;
			addr    = '0;
			st_data = '0;
			exp_be  = 4'b0000;
			case (inst[6:0])
				`RV_OP_LUI: begin
					exp_we = 1'b1;
					res    = {inst[31:12], 12'b0};
				end
				`RV_OP_AUIPC: begin
					exp_we = 1'b1;
					res    = pc + {inst[31:12], 12'b0};
				end
				`RV_OP_JAL: begin
					exp_we  = 1'b1;
					res     = pc + 32'd4;
					next_pc = pc + imm_j;
				end
				`RV_OP_JALR: begin
					exp_we  = 1'b1;
					res     = pc + 32'd4;
					next_pc = (a + imm_i) & ~32'd1;
					bad     = (f3 != 3'd0);
				end
				`RV_OP_BRANCH: begin
					case (f3)
						3'd0: taken = (a == b);
						3'd1: taken = (a != b);
						3'd4: taken = ($signed(a) < $signed(b));
						3'd5: taken = ($signed(a) >= $signed(b));
						3'd6: taken = (a < b);
						3'd7: taken = (a >= b);
						default: bad = 1'b1;
					endcase
					if (taken)
						next_pc = pc + imm_b;
				end
				`RV_OP_LOAD: begin
					exp_we = 1'b1;
					addr   = a + imm_i;
					word   = mem[addr[9:2]] >> {addr[1:0], 3'b000};
					case (f3)
						3'd0: res = {{24{word[7]}}, word[7:0]};
						3'd1: res = {{16{word[15]}}, word[15:0]};
						3'd2: res = word;
						3'd4: res = {24'b0, word[7:0]};
						3'd5: res = {16'b0, word[15:0]};
						default: bad = 1'b1;
					endcase
				end
				`RV_OP_STORE: begin
					exp_st  = 1'b1;
					addr    = a + imm_s;
					st_data = b << {addr[1:0], 3'b000};
					case (f3)
						3'd0: exp_be = 4'b0001 << addr[1:0];
						3'd1: exp_be = 4'b0011 << addr[1:0];
						3'd2: exp_be = 4'b1111;
						default: bad = 1'b1;
					endcase
				end
				`RV_OP_IMM: begin
					exp_we = 1'b1;
					res    = alu_model(f3, (f3 == 3'd5) && inst[30], a, imm_i);
					if (f3 == 3'd1)
						bad = (f7 != 7'h00);
					else if (f3 == 3'd5)
						bad = (f7 != 7'h00) && (f7 != 7'h20);
				end
				`RV_OP_REG: begin
					exp_we = 1'b1;
					res    = alu_model(f3, inst[30], a, b);
					bad    = !((f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
				end
				`RV_OP_SYSTEM: begin
					if (inst == `RV_EBREAK)
						next_pc = pc;
					else
						bad = 1'b1;
				end
				default: bad = 1'b1;
			endcase

			// illegal words retire as a plain pc+4
			if (bad) begin
				exp_we  = 1'b0;
				exp_st  = 1'b0;
				next_pc = pc + 32'd4;
			end
			if (rd == '0)
				exp_we = 1'b0;

			expect_value("pc_o", pc_i, pc);
			expect_value("halt_o", word_t'(halt_i), word_t'(inst == `RV_EBREAK));
			expect_value("invalid_o", word_t'(invalid_i), word_t'(bad));
			expect_value("commit_we_o", word_t'(commit_we_i), word_t'(exp_we));
			if (exp_we) begin
				expect_value("commit_rd_o", word_t'(commit_rd_i), word_t'(rd));
				expect_value("commit_data_o", commit_data_i, res);
			end
			expect_value("dmem_we_o", word_t'(dmem_we_i), word_t'(exp_st));
			if (exp_st) begin
				mask = {{8{exp_be[3]}}, {8{exp_be[2]}}, {8{exp_be[1]}}, {8{exp_be[0]}}};
				expect_value("dmem_addr_o", dmem_addr_i, {addr[31:2], 2'b00});
				expect_value("dmem_be_o", word_t'(dmem_be_i), word_t'(exp_be));
				expect_value("dmem_wdata_o", dmem_wdata_i & mask, st_data & mask);
				for (int k = 0; k < 4; k++)
					if (exp_be[k])
						mem[addr[9:2]][k*8 +: 8] = st_data[k*8 +: 8];
			end

			if (exp_we)
				regs[rd] = res;
			pc = next_pc;
		end
	end

endmodule

`default_nettype wire

// File: tb_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module tb_asserts import rv_pkg::*; (
	input logic      clk,
	input logic      rst,
	input word_t     pc_i,
	input logic      dmem_we_i,
	input logic      halt_i,
	input logic      commit_we_i,
	input reg_addr_t commit_rd_i
);

	int fail_cnt = 0;

	no_store_in_reset: assert property (@(posedge clk) !rst |-> !dmem_we_i)
		else begin
			fail_cnt++;
			$error("dmem write strobe high while reset is held");
		end

	pc_aligned: assert property (@(posedge clk) disable iff (!rst) pc_i[1:0] == 2'b00)
		else begin
			fail_cnt++;
			$error("pc is not word aligned");
		end

	// ebreak freezes the fetch address
	pc_frozen_on_halt: assert property (@(posedge clk) disable iff (!rst)
		halt_i |=> $stable(pc_i))
		else begin
			fail_cnt++;
			$error("pc moved while the core is halted");
		end

	no_x0_commit: assert property (@(posedge clk) disable iff (!rst)
		commit_we_i |-> commit_rd_i != '0)
		else begin
			fail_cnt++;
			$error("register write reported for x0");
		end

endmodule

bind rv_core_top tb_asserts u_asserts (
	.clk         (clk),
	.rst         (rst),
	.pc_i        (pc_o),
	.dmem_we_i   (dmem_we_o),
	.halt_i      (halt_o),
	.commit_we_i (commit_we_o),
	.commit_rd_i (commit_rd_o)
);

`default_nettype wire

// File: tb_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_defines.svh"

module tb_top import rv_pkg::*; ();

	localparam int IMEM_WORDS = 256;
	localparam int DMEM_WORDS = 256;
	// forward-only flow retires each word at most once
	localparam int TIMEOUT_CYCLES = IMEM_WORDS + 10 + 64;

	logic       clk;
	logic       rst;
	word_t      pc;
	word_t      imem_rdata;
	word_t      dmem_addr;
	logic       dmem_we;
	logic [3:0] dmem_be;
	word_t      dmem_wdata;
	word_t      dmem_rdata;
	logic       commit_we;
	reg_addr_t  commit_rd;
	word_t      commit_data;
	logic       halt;
	logic       invalid;
	int         checks;
	int         errors;
	int         assert_fails;
	int         seed;
	int         cycle_cnt = 0;

	word_t imem [IMEM_WORDS];
	word_t dmem [DMEM_WORDS];

	tb_clock_gen u_clock_gen (
		.clk_o (clk)
	);

	rv_core_top dut_i (
		.clk           (clk),
		.rst           (rst),
		.pc_o          (pc),
		.imem_rdata_i  (imem_rdata),
		.dmem_addr_o   (dmem_addr),
		.dmem_we_o     (dmem_we),
		.dmem_be_o     (dmem_be),
		.dmem_wdata_o  (dmem_wdata),
		.dmem_rdata_i  (dmem_rdata),
		.commit_we_o   (commit_we),
		.commit_rd_o   (commit_rd),
		.commit_data_o (commit_data),
		.halt_o        (halt),
		.invalid_o     (invalid)
	);

	tb_checker u_checker (
		.clk           (clk),
		.rst           (rst),
		.pc_i          (pc),
		.dmem_addr_i   (dmem_addr),
		.dmem_we_i     (dmem_we),
		.dmem_be_i     (dmem_be),
		.dmem_wdata_i  (dmem_wdata),
		.commit_we_i   (commit_we),
		.commit_rd_i   (commit_rd),
		.commit_data_i (commit_data),
		.halt_i        (halt),
		.invalid_i     (invalid),
		.checks_o      (checks),
		.errors_o      (errors)
	);

	function automatic word_t itype_word(input logic [11:0] imm, input reg_addr_t rs1,
			input logic [2:0] f3, input reg_addr_t rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic word_t rtype_word(input logic [6:0] f7, input reg_addr_t rs2,
			input reg_addr_t rs1, input logic [2:0] f3, input reg_addr_t rd);
		return {f7, rs2, rs1, f3, rd, `RV_OP_REG};
	endfunction

	function automatic word_t stype_word(input logic [11:0] imm, input reg_addr_t rs2,
			input logic [2:0] f3);
		return {imm[11:5], rs2, 5'd0, f3, imm[4:0], `RV_OP_STORE};
	endfunction

	function automatic word_t btype_word(input logic [12:0] off, input reg_addr_t rs2,
			input reg_addr_t rs1, input logic [2:0] f3);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `RV_OP_BRANCH};
	endfunction

	function automatic word_t utype_word(input logic [19:0] imm, input reg_addr_t rd,
			input logic [6:0] op);
		return {imm, rd, op};
	endfunction

	function automatic word_t jtype_word(input logic [20:0] off, input reg_addr_t rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, `RV_OP_JAL};
	endfunction

	task automatic build_program();
		bit         is_target [IMEM_WORDS];
		int         i;
		int         j;
		int         kind;
		logic [2:0] f3;
		logic [11:0] imm;
		logic       alt;
		reg_addr_t  rd, rs1, rs2;
		word_t      junk;
		i = 0;
		while (i < IMEM_WORDS - 1) begin
			kind = $urandom_range(18, 0);
			// a store at the reset pc keeps the write strobe busy during reset
			if (i == 0)
				kind = 12;
			rd   = reg_addr_t'($urandom);
			rs1  = reg_addr_t'($urandom);
			rs2  = reg_addr_t'($urandom);
			f3   = 3'($urandom);
			imm  = 12'($urandom);
			alt  = 1'($urandom_range(1, 0));
			junk = $urandom;
			// forward target no further than the final ebreak
			j = i + 1 + $urandom_range(15, 0);
			if (j > IMEM_WORDS - 1)
				j = IMEM_WORDS - 1;
			if (kind < 4) begin
				imem[i] = rtype_word((alt && (f3 == 3'd0 || f3 == 3'd5)) ? `RV_F7_ALT :
					`RV_F7_BASE, rs2, rs1, f3, rd);
			end else if (kind < 8) begin
				if (f3 == 3'd1)
					imm[11:5] = `RV_F7_BASE;
				else if (f3 == 3'd5)
					imm[11:5] = alt ? `RV_F7_ALT : `RV_F7_BASE;
				imem[i] = itype_word(imm, rs1, f3, rd, `RV_OP_IMM);
			end else if (kind < 10) begin
				imem[i] = utype_word(20'($urandom), rd, alt ? `RV_OP_LUI : `RV_OP_AUIPC);
			end else if (kind < 12) begin
				case ($urandom_range(4, 0))
					0: f3 = `RV_F3_B;
					1: f3 = `RV_F3_H;
					2: f3 = `RV_F3_W;
					3: f3 = `RV_F3_BU;
					default: f3 = `RV_F3_HU;
				endcase
				imm = 12'($urandom_range(1023, 0)) & ~((12'd1 << f3[1:0]) - 12'd1);
				imem[i] = itype_word(imm, 5'd0, f3, rd, `RV_OP_LOAD);
			end else if (kind < 14) begin
				f3 = 3'($urandom_range(2, 0));
				imm = 12'($urandom_range(1023, 0)) & ~((12'd1 << f3[1:0]) - 12'd1);
				imem[i] = stype_word(imm, rs2, f3);
			end else if (kind == 14) begin
				f3 = 3'($urandom_range(5, 0));
				if (f3 >= 3'd2)
					f3 = f3 + 3'd2;
				imem[i] = btype_word(13'((j - i) * 4), rs2, rs1, f3);
				is_target[j] = 1'b1;
			end else if (kind == 15) begin
				imem[i] = jtype_word(21'((j - i) * 4), rd);
				is_target[j] = 1'b1;
			end else if (kind == 16 && i <= IMEM_WORDS - 5 && !is_target[i + 1] &&
					!is_target[i + 2]) begin
				// lui/addi build the base with bit 0 set so the core has to clear it
				rs1 = reg_addr_t'($urandom_range(31, 1));
				if (j < i + 3)
					j = i + 3;
				imem[i]     = utype_word(20'd0, rs1, `RV_OP_LUI);
				imem[i + 1] = itype_word(12'(j * 4 + 1), rs1, 3'd0, rs1, `RV_OP_IMM);
				imem[i + 2] = itype_word(12'd0, rs1, `RV_F3_JALR, rd, `RV_OP_JALR);
				is_target[j] = 1'b1;
				i = i + 2;
			end else if (kind == 17) begin
				imem[i] = alt ? 32'h0000_0073 : {junk[31:7], 7'b0001111};
			end else begin
				imem[i] = itype_word(imm, rs1, `RV_F3_ADD, rd, `RV_OP_IMM);
			end
			i = i + 1;
		end
		imem[IMEM_WORDS - 1] = `RV_EBREAK;
	endtask

	// instruction word first and then the data word it addresses
	always @(posedge clk) begin
		#1;
		imem_rdata = imem[pc[9:2]];
		#1;
		dmem_rdata = dmem[dmem_addr[9:2]];
	end

	always @(posedge clk) begin
		if (dmem_we) begin
			for (int k = 0; k < 4; k++)
				if (dmem_be[k])
					dmem[dmem_addr[9:2]][k*8 +: 8] <= dmem_wdata[k*8 +: 8];
		end
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("timeout: core did not reach ebreak within %0d cycles", TIMEOUT_CYCLES);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	initial begin
		seed = 32'hfe4f_b2c8;
		void'($urandom(seed));
		rst        = 1'b0;
		imem_rdata = '0;
		dmem_rdata = '0;
		build_program();
		for (int k = 0; k < DMEM_WORDS; k++)
			dmem[k] = (word_t'(k) * 32'h9e37_79b9) ^ 32'h0f1e_2d3c;
		repeat (10)
			@(posedge clk);
		#1 rst = 1'b1;
		while (halt !== 1'b1)
			@(posedge clk);
		// watch the pc hold for a few cycles after ebreak
		repeat (8)
			@(posedge clk);
		assert_fails = dut_i.u_asserts.fail_cnt;
		$display("checks %0d, check errors %0d, assertion failures %0d", checks, errors,
			assert_fails);
		if (errors == 0 && assert_fails == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
+incdir+.
rv_pkg.sv
rv_stage_if.sv
rv_pc_counter.sv
rv_regfile.sv
rv_decoder.sv
rv_execute.sv
rv_writeback.sv
rv_core_top.sv
tb_clock_gen.sv
tb_checker.sv
tb_asserts.sv
tb_top.sv
